// File: Bender.yml
package:
  name: kat_adc_interface

dependencies: {}

sources:
  - files:
      - common/adc_pkg.sv
      - capture/adc_ddr_capture.sv
      - capture/adc_sync_sampler.sv
      - fifo/adc_async_fifo.sv
      - src/adc_user_unpack.sv
      - src/kat_adc_interface.sv

  - target: test
    files:
      - test/tb_kat_adc_interface.sv

// File: capture/adc_ddr_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_ddr_capture (
  input  wire                   adc_clk,
  input  wire                   dcm_reset,
  input  wire adc_pkg::sample_t adc_di_d,
  input  wire adc_pkg::sample_t adc_di,
  input  wire adc_pkg::sample_t adc_dq_d,
  input  wire adc_pkg::sample_t adc_dq,
  input  wire                   adc_overrange,
  output adc_pkg::sample_t      di_d_rise,
  output adc_pkg::sample_t      di_rise,
  output adc_pkg::sample_t      di_d_fall,
  output adc_pkg::sample_t      di_fall,
  output adc_pkg::sample_t      dq_d_rise,
  output adc_pkg::sample_t      dq_rise,
  output adc_pkg::sample_t      dq_d_fall,
  output adc_pkg::sample_t      dq_fall,
  output adc_pkg::ovr_t         overrange
);

  localparam int SW    = adc_pkg::SAMPLE_W;
  localparam int BUS_W = 4 * SW + 1;

  // all input pins side by side, over-range on top
  typedef logic [BUS_W-1:0] pin_bus_t;

  pin_bus_t pins;
  pin_bus_t rise_q;
  pin_bus_t fall_q;
  pin_bus_t rise_out;
  pin_bus_t fall_out;

  assign pins = {adc_overrange, adc_dq, adc_dq_d, adc_di, adc_di_d};

  // first stage, rising half
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      rise_q <= '0;
    end else begin
      rise_q <= pins;
    end
  end

  // first stage, falling half
  always_ff @(negedge adc_clk) begin
    if (dcm_reset) begin
      fall_q <= '0;
    end else begin
      fall_q <= pins;
    end
  end

  // same-edge pipelined: both halves of a period leave on the next rise
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      rise_out <= '0;
      fall_out <= '0;
    end else begin
      rise_out <= rise_q;
      fall_out <= fall_q;
    end
  end

  assign di_d_rise = rise_out[SW-1:0];
  assign di_rise   = rise_out[2*SW-1:SW];
  assign dq_d_rise = rise_out[3*SW-1:2*SW];
  assign dq_rise   = rise_out[4*SW-1:3*SW];

  assign di_d_fall = fall_out[SW-1:0];
  assign di_fall   = fall_out[2*SW-1:SW];
  assign dq_d_fall = fall_out[3*SW-1:2*SW];
  assign dq_fall   = fall_out[4*SW-1:3*SW];

  // bit 0 rising half, bit 1 falling half
  assign overrange = {fall_out[4*SW], rise_out[4*SW]};

endmodule

`default_nettype wire

// File: capture/adc_sync_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sync_sampler (
  input  wire             adc_clk,
  input  wire             adc_clk90,
  input  wire             dcm_reset,
  input  wire             adc_sync,
  output adc_pkg::phase_t sync_phase
);

  logic sync_0;
  logic sync_90;
  logic sync_180;
  logic sync_270;

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      sync_0 <= 1'b0;
    end else begin
      sync_0 <= adc_sync;
    end
  end

  always_ff @(posedge adc_clk90) begin
    if (dcm_reset) begin
      sync_90 <= 1'b0;
    end else begin
      sync_90 <= adc_sync;
    end
  end

  always_ff @(negedge adc_clk) begin
    if (dcm_reset) begin
      sync_180 <= 1'b0;
    end else begin
      sync_180 <= adc_sync;
    end
  end

  always_ff @(negedge adc_clk90) begin
    if (dcm_reset) begin
      sync_270 <= 1'b0;
    end else begin
      sync_270 <= adc_sync;
    end
  end

  // one retime stage, lines up with the data capture
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      sync_phase <= '0;
    end else begin
      sync_phase <= {sync_270, sync_180, sync_90, sync_0};
    end
  end

endmodule

`default_nettype wire

// File: common/adc_pkg.sv
`default_nettype none

package adc_pkg;

  // raw ADC sample
  localparam int SAMPLE_W = 8;

  // sync seen at 0, 90, 180 and 270 degrees
  localparam int PHASE_W = 4;

  // over-range, rising half then falling half
  localparam int OVR_W = 2;

  // four samples per channel per adc_clk period
  localparam int LANES = 8;

  // capture word layout, low to high
  // i0 i1 i2 i3 q0 q1 q2 q3 ovr phase
  localparam int OVR_LSB   = LANES * SAMPLE_W;
  localparam int PHASE_LSB = OVR_LSB + OVR_W;
  localparam int CAPTURE_W = PHASE_LSB + PHASE_W;

  // depth 16
  localparam int FIFO_ADDR_W_DEFAULT = 4;

  typedef logic [SAMPLE_W-1:0]  sample_t;
  typedef logic [PHASE_W-1:0]   phase_t;
  typedef logic [OVR_W-1:0]     ovr_t;
  typedef logic [CAPTURE_W-1:0] capture_word_t;

endpackage

`default_nettype wire

// File: fifo/adc_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module adc_async_fifo #(
  parameter int ADDR_W = adc_pkg::FIFO_ADDR_W_DEFAULT
) (
  input  wire                         wr_clk,
  input  wire                         wr_reset,
  input  wire                         wr_en,
  input  wire adc_pkg::capture_word_t din,
  input  wire                         rd_clk,
  input  wire                         rd_reset,
  input  wire                         rd_en,
  output adc_pkg::capture_word_t      dout,
  output logic                        empty,
  output logic                        full
);

  localparam int DEPTH = 2 ** ADDR_W;

  // one extra bit tells a wrapped pointer from an equal one
  typedef logic [ADDR_W:0]   ptr_t;
  typedef logic [ADDR_W-1:0] addr_t;

  adc_pkg::capture_word_t mem [DEPTH];

  ptr_t  wr_bin;
  ptr_t  wr_bin_next;
  ptr_t  wr_gray;
  ptr_t  rd_gray_s1;
  ptr_t  rd_gray_s2;
  addr_t wr_addr;
  logic  wr_go;

  ptr_t  rd_bin;
  ptr_t  rd_bin_next;
  ptr_t  rd_gray;
  ptr_t  wr_gray_s1;
  ptr_t  wr_gray_s2;
  addr_t rd_addr;
  logic  rd_go;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // write side

  assign wr_go       = wr_en && !full;
  assign wr_bin_next = wr_bin + ptr_t'(1);
  assign wr_addr     = wr_bin[ADDR_W-1:0];

  always_ff @(posedge wr_clk) begin
    if (wr_go) begin
      mem[wr_addr] <= din;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_go) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= bin2gray(wr_bin_next);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // full when the writer is one lap ahead, top two gray bits inverted
  assign full = (wr_gray == {~rd_gray_s2[ADDR_W:ADDR_W-1], rd_gray_s2[ADDR_W-2:0]});

  // read side

  assign rd_go       = rd_en && !empty;
  assign rd_bin_next = rd_bin + ptr_t'(1);
  assign rd_addr     = rd_bin[ADDR_W-1:0];

  always_ff @(posedge rd_clk) begin
    if (rd_go) begin
      dout <= mem[rd_addr];
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_go) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= bin2gray(rd_bin_next);
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign empty = (rd_gray == wr_gray_s2);

endmodule

`default_nettype wire

// File: list.f
common/adc_pkg.sv
capture/adc_ddr_capture.sv
capture/adc_sync_sampler.sv
fifo/adc_async_fifo.sv
src/adc_user_unpack.sv
src/kat_adc_interface.sv
test/tb_kat_adc_interface.sv

// File: src/adc_user_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module adc_user_unpack (
  input  wire                         ctrl_clk,
  input  wire                         ctrl_reset,
  input  wire                         fifo_empty,
  input  wire adc_pkg::capture_word_t fifo_dout,
  output logic                        fifo_rd_en,
  output adc_pkg::sample_t            user_datai0,
  output adc_pkg::sample_t            user_datai1,
  output adc_pkg::sample_t            user_datai2,
  output adc_pkg::sample_t            user_datai3,
  output adc_pkg::sample_t            user_dataq0,
  output adc_pkg::sample_t            user_dataq1,
  output adc_pkg::sample_t            user_dataq2,
  output adc_pkg::sample_t            user_dataq3,
  output adc_pkg::ovr_t               user_overrange,
  output adc_pkg::phase_t             user_sync,
  output logic                        user_data_valid
);

  localparam int SW = adc_pkg::SAMPLE_W;

  // dout holds a fresh word this cycle
  logic dout_new;

  // reader outpaces the ADC, so drain on every not-empty
  assign fifo_rd_en = !fifo_empty;

  always_ff @(posedge ctrl_clk) begin
    if (ctrl_reset) begin
      dout_new        <= 1'b0;
      user_data_valid <= 1'b0;
    end else begin
      dout_new        <= fifo_rd_en;
      user_data_valid <= dout_new;
    end
  end

  // lanes hold between valid pulses
  always_ff @(posedge ctrl_clk) begin
    if (dout_new) begin
      user_datai0    <= fifo_dout[0*SW +: SW];
      user_datai1    <= fifo_dout[1*SW +: SW];
      user_datai2    <= fifo_dout[2*SW +: SW];
      user_datai3    <= fifo_dout[3*SW +: SW];
      user_dataq0    <= fifo_dout[4*SW +: SW];
      user_dataq1    <= fifo_dout[5*SW +: SW];
      user_dataq2    <= fifo_dout[6*SW +: SW];
      user_dataq3    <= fifo_dout[7*SW +: SW];
      user_overrange <= fifo_dout[adc_pkg::OVR_LSB +: adc_pkg::OVR_W];
      user_sync      <= fifo_dout[adc_pkg::PHASE_LSB +: adc_pkg::PHASE_W];
    end
  end

endmodule

`default_nettype wire

// File: src/kat_adc_interface.sv
`timescale 1ns/1ps
`default_nettype none

module kat_adc_interface #(
  parameter int FIFO_ADDR_W = adc_pkg::FIFO_ADDR_W_DEFAULT
) (
  input  wire                   adc_clk,
  input  wire                   adc_clk90,
  input  wire                   dcm_reset,
  input  wire                   ctrl_clk,
  input  wire                   ctrl_reset,
  input  wire adc_pkg::sample_t adc_di_d,
  input  wire adc_pkg::sample_t adc_di,
  input  wire adc_pkg::sample_t adc_dq_d,
  input  wire adc_pkg::sample_t adc_dq,
  input  wire                   adc_overrange,
  input  wire                   adc_sync,
  output adc_pkg::sample_t      user_datai0,
  output adc_pkg::sample_t      user_datai1,
  output adc_pkg::sample_t      user_datai2,
  output adc_pkg::sample_t      user_datai3,
  output adc_pkg::sample_t      user_dataq0,
  output adc_pkg::sample_t      user_dataq1,
  output adc_pkg::sample_t      user_dataq2,
  output adc_pkg::sample_t      user_dataq3,
  output adc_pkg::ovr_t         user_overrange,
  output adc_pkg::phase_t       user_sync,
  output logic                  user_data_valid
);

  adc_pkg::sample_t       di_d_rise;
  adc_pkg::sample_t       di_rise;
  adc_pkg::sample_t       di_d_fall;
  adc_pkg::sample_t       di_fall;
  adc_pkg::sample_t       dq_d_rise;
  adc_pkg::sample_t       dq_rise;
  adc_pkg::sample_t       dq_d_fall;
  adc_pkg::sample_t       dq_fall;
  adc_pkg::ovr_t          overrange;
  adc_pkg::phase_t        sync_phase;
  adc_pkg::capture_word_t capture_word;
  adc_pkg::capture_word_t fifo_dout;
  logic [1:0]             live_pipe;
  logic                   capture_live;
  logic                   fifo_rd_en;
  logic                   fifo_empty;

  adc_ddr_capture u_capture (
    .adc_clk       (adc_clk),
    .dcm_reset     (dcm_reset),
    .adc_di_d      (adc_di_d),
    .adc_di        (adc_di),
    .adc_dq_d      (adc_dq_d),
    .adc_dq        (adc_dq),
    .adc_overrange (adc_overrange),
    .di_d_rise     (di_d_rise),
    .di_rise       (di_rise),
    .di_d_fall     (di_d_fall),
    .di_fall       (di_fall),
    .dq_d_rise     (dq_d_rise),
    .dq_rise       (dq_rise),
    .dq_d_fall     (dq_d_fall),
    .dq_fall       (dq_fall),
    .overrange     (overrange)
  );

  adc_sync_sampler u_sync (
    .adc_clk    (adc_clk),
    .adc_clk90  (adc_clk90),
    .dcm_reset  (dcm_reset),
    .adc_sync   (adc_sync),
    .sync_phase (sync_phase)
  );

  // first real period reaches the capture outputs two cycles after release
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      live_pipe <= '0;
    end else begin
      live_pipe <= {live_pipe[0], 1'b1};
    end
  end

  assign capture_live = live_pipe[1];

  assign capture_word = {sync_phase, overrange,
                         dq_fall, dq_d_fall, dq_rise, dq_d_rise,
                         di_fall, di_d_fall, di_rise, di_d_rise};

  // full drops the write, reader is faster by spec
  adc_async_fifo #(
    .ADDR_W (FIFO_ADDR_W)
  ) u_fifo (
    .wr_clk   (adc_clk),
    .wr_reset (dcm_reset),
    .wr_en    (capture_live),
    .din      (capture_word),
    .rd_clk   (ctrl_clk),
    .rd_reset (ctrl_reset),
    .rd_en    (fifo_rd_en),
    .dout     (fifo_dout),
    .empty    (fifo_empty),
    .full     ()
  );

  adc_user_unpack u_unpack (
    .ctrl_clk        (ctrl_clk),
    .ctrl_reset      (ctrl_reset),
    .fifo_empty      (fifo_empty),
    .fifo_dout       (fifo_dout),
    .fifo_rd_en      (fifo_rd_en),
    .user_datai0     (user_datai0),
    .user_datai1     (user_datai1),
    .user_datai2     (user_datai2),
    .user_datai3     (user_datai3),
    .user_dataq0     (user_dataq0),
    .user_dataq1     (user_dataq1),
    .user_dataq2     (user_dataq2),
    .user_dataq3     (user_dataq3),
    .user_overrange  (user_overrange),
    .user_sync       (user_sync),
    .user_data_valid (user_data_valid)
  );

endmodule

`default_nettype wire

// File: test/tb_kat_adc_interface.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kat_adc_interface;

  localparam int SW            = adc_pkg::SAMPLE_W;
  localparam int OVR_AT        = 8 * SW;
  localparam int SYNC_AT       = OVR_AT + 2;
  localparam int RESET_CYCLES  = 5;
  localparam int N_FIRST       = 16;
  localparam int N_RANDOM      = 1000;
  localparam int N_OVR         = 12;
  localparam int N_SYNC        = 12;
  localparam int N_RESTART     = 24;
  localparam int RESET_PERIODS = 10;
  localparam int DRAIN_CYCLES  = 100;
  localparam int TOTAL_PERIODS = N_FIRST + N_RANDOM + N_OVR + N_SYNC + 2 * N_RESTART
                                 + 2 * RESET_PERIODS + DRAIN_CYCLES;
  // twice the nominal run plus 2 us of slack
  localparam int WATCHDOG_NS   = TOTAL_PERIODS * 40 * 2 + 2000;

  // pin values held for one half period
  typedef struct packed {
    logic             sync;
    logic             ovr;
    adc_pkg::sample_t dq;
    adc_pkg::sample_t dq_d;
    adc_pkg::sample_t di;
    adc_pkg::sample_t di_d;
  } half_t;

  typedef struct packed {
    half_t fall;
    half_t rise;
  } period_t;

  logic             adc_clk;
  logic             adc_clk90;
  logic             ctrl_clk;
  logic             dcm_reset;
  logic             ctrl_reset;
  adc_pkg::sample_t adc_di_d;
  adc_pkg::sample_t adc_di;
  adc_pkg::sample_t adc_dq_d;
  adc_pkg::sample_t adc_dq;
  logic             adc_overrange;
  logic             adc_sync;
  adc_pkg::sample_t user_datai0;
  adc_pkg::sample_t user_datai1;
  adc_pkg::sample_t user_datai2;
  adc_pkg::sample_t user_datai3;
  adc_pkg::sample_t user_dataq0;
  adc_pkg::sample_t user_dataq1;
  adc_pkg::sample_t user_dataq2;
  adc_pkg::sample_t user_dataq3;
  adc_pkg::ovr_t    user_overrange;
  adc_pkg::phase_t  user_sync;
  logic             user_data_valid;

  period_t pending_q[$];
  period_t expect_q[$];
  logic    record;
  int      errors;
  int      words_checked;

  kat_adc_interface #(
    .FIFO_ADDR_W (adc_pkg::FIFO_ADDR_W_DEFAULT)
  ) DUT (
    .adc_clk         (adc_clk),
    .adc_clk90       (adc_clk90),
    .dcm_reset       (dcm_reset),
    .ctrl_clk        (ctrl_clk),
    .ctrl_reset      (ctrl_reset),
    .adc_di_d        (adc_di_d),
    .adc_di          (adc_di),
    .adc_dq_d        (adc_dq_d),
    .adc_dq          (adc_dq),
    .adc_overrange   (adc_overrange),
    .adc_sync        (adc_sync),
    .user_datai0     (user_datai0),
    .user_datai1     (user_datai1),
    .user_datai2     (user_datai2),
    .user_datai3     (user_datai3),
    .user_dataq0     (user_dataq0),
    .user_dataq1     (user_dataq1),
    .user_dataq2     (user_dataq2),
    .user_dataq3     (user_dataq3),
    .user_overrange  (user_overrange),
    .user_sync       (user_sync),
    .user_data_valid (user_data_valid)
  );

  always #20 adc_clk = ~adc_clk;
  always #18 ctrl_clk = ~ctrl_clk;

  // quarter period behind adc_clk
  always @(adc_clk) adc_clk90 <= #10 adc_clk;

  function automatic half_t random_half();
    half_t h;
    h      = '0;
    h.di_d = adc_pkg::sample_t'($urandom);
    h.di   = adc_pkg::sample_t'($urandom);
    h.dq_d = adc_pkg::sample_t'($urandom);
    h.dq   = adc_pkg::sample_t'($urandom);
    return h;
  endfunction

  // 0 and 90 degree samples land in the rising-half drive window,
  // 180 and 270 in the falling-half one
  function automatic adc_pkg::capture_word_t expected_word(input period_t p);
    adc_pkg::phase_t ph;
    ph = {p.fall.sync, p.fall.sync, p.rise.sync, p.rise.sync};
    return {ph, p.fall.ovr, p.rise.ovr,
            p.fall.dq, p.fall.dq_d, p.rise.dq, p.rise.dq_d,
            p.fall.di, p.fall.di_d, p.rise.di, p.rise.di_d};
  endfunction

  task automatic check_lane(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic drive_half(input half_t h);
    adc_di_d      <= h.di_d;
    adc_di        <= h.di;
    adc_dq_d      <= h.dq_d;
    adc_dq        <= h.dq;
    adc_overrange <= h.ovr;
    adc_sync      <= h.sync;
  endtask

  // pins change 5 ns after each adc_clk90 edge, clear of both adc_clk edges
  always begin : pin_model
    period_t cur;
    @(negedge adc_clk90);
    #5;
    if (pending_q.size() != 0) begin
      cur = pending_q.pop_front();
    end else begin
      cur = '0;
    end
    drive_half(cur.rise);
    @(posedge adc_clk90);
    #5;
    drive_half(cur.fall);
    if (record) begin
      expect_q.push_back(cur);
    end
  end

  always @(negedge ctrl_clk) begin : check_words
    period_t                p;
    adc_pkg::capture_word_t exp;
    if (user_data_valid === 1'b1) begin
      if (expect_q.size() == 0) begin
        if (record) begin
          errors++;
          $display("user_data_valid pulsed at %0t with no captured period to match", $time);
        end
      end else begin
        p   = expect_q.pop_front();
        exp = expected_word(p);
        check_lane("user_datai0", exp[0*SW +: SW], user_datai0);
        check_lane("user_datai1", exp[1*SW +: SW], user_datai1);
        check_lane("user_datai2", exp[2*SW +: SW], user_datai2);
        check_lane("user_datai3", exp[3*SW +: SW], user_datai3);
        check_lane("user_dataq0", exp[4*SW +: SW], user_dataq0);
        check_lane("user_dataq1", exp[5*SW +: SW], user_dataq1);
        check_lane("user_dataq2", exp[6*SW +: SW], user_dataq2);
        check_lane("user_dataq3", exp[7*SW +: SW], user_dataq3);
        check_lane("user_overrange", 8'(exp[OVR_AT +: 2]), 8'(user_overrange));
        check_lane("user_sync", 8'(exp[SYNC_AT +: 4]), 8'(user_sync));
        words_checked++;
      end
    end
  end

  task automatic apply_reset();
    record = 1'b0;
    @(negedge ctrl_clk);
    ctrl_reset <= 1'b1;
    @(negedge adc_clk);
    dcm_reset <= 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge adc_clk);
      if (user_data_valid !== 1'b0) begin
        errors++;
        $display("ERR t=%0t user_data_valid expected 0 actual %b", $time, user_data_valid);
      end
      if (DUT.fifo_rd_en !== 1'b0) begin
        errors++;
        $display("ERR t=%0t fifo_rd_en expected 0 actual %b", $time, DUT.fifo_rd_en);
      end
    end
    expect_q.delete();
    @(negedge ctrl_clk);
    ctrl_reset <= 1'b0;
    @(negedge adc_clk);
    dcm_reset <= 1'b0;
    record = 1'b1;
  endtask

  task automatic wait_pins_idle();
    while (pending_q.size() != 0) begin
      @(negedge adc_clk);
    end
  endtask

  task automatic drain_words();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge ctrl_clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("%0d captured periods never reached the user ports", expect_q.size());
    end
  endtask

  initial begin : main
    int      i;
    period_t p;
    adc_clk       = 1'b0;
    adc_clk90     = 1'b0;
    ctrl_clk      = 1'b0;
    dcm_reset     = 1'b1;
    ctrl_reset    = 1'b1;
    adc_di_d      = '0;
    adc_di        = '0;
    adc_dq_d      = '0;
    adc_dq        = '0;
    adc_overrange = 1'b0;
    adc_sync      = 1'b0;
    record        = 1'b0;
    errors        = 0;
    words_checked = 0;
    void'($urandom(55));

    apply_reset();
    for (i = 0; i < N_FIRST + N_RANDOM; i++) begin
      p.rise = random_half();
      p.fall = random_half();
      pending_q.push_back(p);
    end
    wait_pins_idle();

    // rise only, fall only, both, neither
    for (i = 0; i < N_OVR; i++) begin
      p.rise     = random_half();
      p.fall     = random_half();
      p.rise.ovr = (i % 4 == 0) || (i % 4 == 2);
      p.fall.ovr = (i % 4 == 1) || (i % 4 == 2);
      pending_q.push_back(p);
    end
    wait_pins_idle();

    // sync held one full period starting at the falling-half drive
    for (i = 0; i < N_SYNC; i++) begin
      p.rise      = random_half();
      p.fall      = random_half();
      p.fall.sync = (i % 4 == 0);
      p.rise.sync = (i % 4 == 1);
      pending_q.push_back(p);
    end
    wait_pins_idle();

    for (i = 0; i < N_RESTART; i++) begin
      p.rise = random_half();
      p.fall = random_half();
      pending_q.push_back(p);
    end
    wait_pins_idle();
    apply_reset();
    for (i = 0; i < N_RESTART; i++) begin
      p.rise = random_half();
      p.fall = random_half();
      pending_q.push_back(p);
    end
    wait_pins_idle();

    @(negedge adc_clk);
    record = 1'b0;
    drain_words();

    $display("Checked %0d words, %0d errors", words_checked, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checked %0d words, %0d errors", words_checked, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
